//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= list.f
TOP       ?= tb_mem_sys
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "RESULT: PASS" $(LOG); then echo "Simulation ended early"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- cfg_cmd_source.sv
//#################################################
// Loader owns the link until done; ext waits before
//#################################################
`timescale 1ns/1ns
`include "mem_sys_params.svh"

module cfg_cmd_source
   import mem_sys_pkg::*;
(
   input  logic                       clk_i,
   input  logic                       rst_n_i,

   input  logic                       ext_cyc_i,
   input  logic                       ext_stb_i,
   input  logic                       ext_we_i,
   input  ms_addr_u                   ext_adr_i,
   input  logic [`MS_DATA_WIDTH-1:0]  ext_dat_i,
   input  logic [`MS_SEL_WIDTH-1:0]   ext_sel_i,
   output logic [`MS_DATA_WIDTH-1:0]  ext_dat_o,
   output logic                       ext_ack_o,
   output logic                       ext_err_o,

   output logic                       src_cyc_o,
   output logic                       src_stb_o,
   output logic                       src_we_o,
   output ms_addr_u                   src_adr_o,
   output logic [`MS_DATA_WIDTH-1:0]  src_dat_o,
   output logic [`MS_SEL_WIDTH-1:0]   src_sel_o,
   input  logic [`MS_DATA_WIDTH-1:0]  src_dat_i,
   input  logic                       src_ack_i,
   input  logic                       src_err_i,

   output logic                       cfg_done_o
);

   // Step 0 is idle after reset, steps 1..3 are the loader writes
   logic [1:0]                 step_q;
   logic                       done_q;
   ms_addr_u                   cfg_adr;
   logic [`MS_DATA_WIDTH-1:0]  cfg_dat;

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         step_q <= 2'd0;
         done_q <= 1'b0;
      end
      else if (!done_q)
      begin
         if (step_q == 2'd0)
            step_q <= 2'd1;
         else if (src_ack_i)
         begin
            if (step_q == 2'(`MS_CFG_STEPS))
               done_q <= 1'b1;
            else
               step_q <= step_q + 2'd1;
         end
      end
   end

   always_comb
   begin
      cfg_adr        = '0;
      cfg_adr.io.dev = `MS_DEV_CFG;
      cfg_dat        = '0;
      case (step_q)
         2'd1:
         begin
            cfg_adr.io.reg_off = `MS_REG_FREEZE;
            cfg_dat            = `MS_DATA_WIDTH'(1);
         end
         2'd2:
         begin
            cfg_adr.io.reg_off = `MS_REG_CORE_ID;
            cfg_dat            = `MS_CORE_ID_VALUE;
         end
         default:
         begin
            // Last step clears freeze
            cfg_adr.io.reg_off = `MS_REG_FREEZE;
            cfg_dat            = '0;
         end
      endcase
   end

   // Fixed arbitration, the two owners never overlap
   always_comb
   begin
      if (!done_q)
      begin
         src_cyc_o = (step_q != 2'd0);
         src_stb_o = (step_q != 2'd0);
         src_we_o  = 1'b1;
         src_adr_o = cfg_adr;
         src_dat_o = cfg_dat;
         src_sel_o = '1;
         ext_dat_o = '0;
         ext_ack_o = 1'b0;
         ext_err_o = 1'b0;
      end
      else
      begin
         src_cyc_o = ext_cyc_i;
         src_stb_o = ext_stb_i;
         src_we_o  = ext_we_i;
         src_adr_o = ext_adr_i;
         src_dat_o = ext_dat_i;
         src_sel_o = ext_sel_i;
         ext_dat_o = src_dat_i;
         ext_ack_o = src_ack_i;
         ext_err_o = src_err_i;
      end
   end

   assign cfg_done_o = done_q;

endmodule

//--- cmd_bridge_fifo.sv
//#################################################
// Writes are posted and their errors dropped
// One read in flight; master must hold it until answered
//#################################################
`timescale 1ns/1ns
`include "mem_sys_params.svh"

module cmd_bridge_fifo
   import mem_sys_pkg::*;
(
   input  logic                       clk_i,
   input  logic                       rst_n_i,

   input  logic                       s_cyc_i,
   input  logic                       s_stb_i,
   input  logic                       s_we_i,
   input  ms_addr_u                   s_adr_i,
   input  logic [`MS_DATA_WIDTH-1:0]  s_dat_i,
   input  logic [`MS_SEL_WIDTH-1:0]   s_sel_i,
   output logic [`MS_DATA_WIDTH-1:0]  s_dat_o,
   output logic                       s_ack_o,
   output logic                       s_err_o,

   output logic                       m_cyc_o,
   output logic                       m_stb_o,
   output logic                       m_we_o,
   output ms_addr_u                   m_adr_o,
   output logic [`MS_DATA_WIDTH-1:0]  m_dat_o,
   output logic [`MS_SEL_WIDTH-1:0]   m_sel_o,
   input  logic [`MS_DATA_WIDTH-1:0]  m_dat_i,
   input  logic                       m_ack_i,
   input  logic                       m_err_i
);

   localparam int PTR_W = $clog2(`MS_FIFO_DEPTH);

   logic                       fifo_we  [`MS_FIFO_DEPTH];
   ms_addr_u                   fifo_adr [`MS_FIFO_DEPTH];
   logic [`MS_DATA_WIDTH-1:0]  fifo_dat [`MS_FIFO_DEPTH];
   logic [`MS_SEL_WIDTH-1:0]   fifo_sel [`MS_FIFO_DEPTH];

   // Pointers carry one wrap bit above the index
   logic [PTR_W:0]             wr_ptr_q;
   logic [PTR_W:0]             rd_ptr_q;
   logic [PTR_W-1:0]           wr_idx;
   logic [PTR_W-1:0]           rd_idx;
   logic                       rd_pend_q;
   logic                       fifo_empty;
   logic                       fifo_full;
   logic                       s_req;
   logic                       push;
   logic                       pop;
   logic                       rd_done;

   assign wr_idx     = wr_ptr_q[PTR_W-1:0];
   assign rd_idx     = rd_ptr_q[PTR_W-1:0];
   assign fifo_empty = (wr_ptr_q == rd_ptr_q);
   assign fifo_full  = (wr_ptr_q[PTR_W] != rd_ptr_q[PTR_W]) && (wr_idx == rd_idx);

   // Ignore the request on its own response cycle
   assign s_req = s_cyc_i && s_stb_i && !s_ack_o && !s_err_o;

   // A read enters once, then the slave side waits on it
   assign push    = s_req && !fifo_full && (s_we_i || !rd_pend_q);
   assign pop     = !fifo_empty && (m_ack_i || m_err_i);
   assign rd_done = pop && !m_we_o;

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         wr_ptr_q  <= '0;
         rd_ptr_q  <= '0;
         rd_pend_q <= 1'b0;
         s_ack_o   <= 1'b0;
         s_err_o   <= 1'b0;
      end
      else
      begin
         s_ack_o <= (push && s_we_i) || (rd_done && m_ack_i);
         s_err_o <= rd_done && m_err_i;
         if (push)
            wr_ptr_q <= wr_ptr_q + (PTR_W+1)'(1);
         if (pop)
            rd_ptr_q <= rd_ptr_q + (PTR_W+1)'(1);
         if (push && !s_we_i)
            rd_pend_q <= 1'b1;
         else if (rd_done)
            rd_pend_q <= 1'b0;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (push)
      begin
         fifo_we[wr_idx]  <= s_we_i;
         fifo_adr[wr_idx] <= s_adr_i;
         fifo_dat[wr_idx] <= s_dat_i;
         fifo_sel[wr_idx] <= s_sel_i;
      end
      if (rd_done)
         s_dat_o <= m_dat_i;
   end

   // Head of the queue is presented until the target answers
   assign m_cyc_o = !fifo_empty;
   assign m_stb_o = !fifo_empty;
   assign m_we_o  = fifo_we[rd_idx];
   assign m_adr_o = fifo_adr[rd_idx];
   assign m_dat_o = fifo_dat[rd_idx];
   assign m_sel_o = fifo_sel[rd_idx];

endmodule

//--- list.f
+incdir+.
mem_sys_pkg.sv
cfg_cmd_source.sv
cmd_bridge_fifo.sv
mem_io_target.sv
mem_sys_top.sv
tb_mem_sys.sv

//--- mem_io_target.sv
//#################################################
// One-cycle registered ack/err; DRAM has no reset
// Config and host writes ignore sel
//#################################################
`timescale 1ns/1ns
`include "mem_sys_params.svh"

module mem_io_target
   import mem_sys_pkg::*;
(
   input  logic                       clk_i,
   input  logic                       rst_n_i,

   input  logic                       cyc_i,
   input  logic                       stb_i,
   input  logic                       we_i,
   input  ms_addr_u                   adr_i,
   input  logic [`MS_DATA_WIDTH-1:0]  dat_i,
   input  logic [`MS_SEL_WIDTH-1:0]   sel_i,
   output logic [`MS_DATA_WIDTH-1:0]  dat_o,
   output logic                       ack_o,
   output logic                       err_o,

   output logic                       freeze_o,
   output logic                       finish_o,
   output logic [`MS_DATA_WIDTH-1:0]  finish_code_o
);

   localparam int IDX_W = $clog2(`MS_MEM_WORDS);

   logic [`MS_DATA_WIDTH-1:0]  mem [`MS_MEM_WORDS];
   logic                       freeze_q;
   logic [`MS_DATA_WIDTH-1:0]  core_id_q;
   logic                       req;
   logic                       is_dram;
   logic                       dram_hit;
   logic                       cfg_freeze_hit;
   logic                       cfg_core_id_hit;
   logic                       host_finish_hit;
   logic                       hit;
   logic [IDX_W-1:0]           mem_idx;
   logic [`MS_DATA_WIDTH-1:0]  io_rd_data;

   // Transfer is still open on the response cycle, skip it
   assign req = cyc_i && stb_i && !ack_o && !err_o;

   assign is_dram  = adr_i.dram.is_dram;
   assign mem_idx  = adr_i.dram.offset[IDX_W+1:2];
   // Word index past the array when any upper offset bit is set
   assign dram_hit = is_dram && (adr_i.dram.offset[`MS_ADDR_WIDTH-2:IDX_W+2] == '0);

   assign cfg_freeze_hit  = !is_dram && (adr_i.io.dev == `MS_DEV_CFG) &&
                            (adr_i.io.reg_off == `MS_REG_FREEZE);
   assign cfg_core_id_hit = !is_dram && (adr_i.io.dev == `MS_DEV_CFG) &&
                            (adr_i.io.reg_off == `MS_REG_CORE_ID);
   assign host_finish_hit = !is_dram && (adr_i.io.dev == `MS_DEV_HOST) &&
                            (adr_i.io.reg_off == `MS_REG_FINISH);

   assign hit = dram_hit || cfg_freeze_hit || cfg_core_id_hit || host_finish_hit;

   always_comb
   begin
      io_rd_data = '0;
      if (cfg_freeze_hit)
         io_rd_data = `MS_DATA_WIDTH'(freeze_q);
      else if (cfg_core_id_hit)
         io_rd_data = core_id_q;
      else if (host_finish_hit)
         io_rd_data = finish_code_o;
   end

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         ack_o         <= 1'b0;
         err_o         <= 1'b0;
         freeze_q      <= 1'b1;
         core_id_q     <= '0;
         finish_o      <= 1'b0;
         finish_code_o <= '0;
      end
      else
      begin
         ack_o <= req && hit;
         err_o <= req && !hit;
         if (req && we_i)
         begin
            if (cfg_freeze_hit)
               freeze_q <= dat_i[0];
            if (cfg_core_id_hit)
               core_id_q <= dat_i;
            if (host_finish_hit)
            begin
               finish_o      <= 1'b1;
               finish_code_o <= dat_i;
            end
         end
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (req && dram_hit)
      begin
         if (we_i)
         begin
            for (int b = 0; b < `MS_SEL_WIDTH; b++)
            begin
               if (sel_i[b])
                  mem[mem_idx][8*b +: 8] <= dat_i[8*b +: 8];
            end
         end
         else
            dat_o <= mem[mem_idx];
      end
      else if (req && !we_i)
         dat_o <= io_rd_data;
   end

   assign freeze_o = freeze_q;

endmodule

//--- mem_sys_params.svh
//#################################################
// Widths, address map and config sequence constants
// Memory words and FIFO depth must be powers of two
//#################################################
`ifndef MEM_SYS_PARAMS_SVH
`define MEM_SYS_PARAMS_SVH

`define MS_ADDR_WIDTH 32
`define MS_DATA_WIDTH 32
`define MS_SEL_WIDTH 4

// Address field widths of the I/O view
`define MS_DEV_WIDTH 8
`define MS_REG_WIDTH 16

`define MS_MEM_WORDS 1024
`define MS_FIFO_DEPTH 4

// I/O device ids
`define MS_DEV_HOST 8'h01
`define MS_DEV_CFG 8'h02

// Register offsets within a device
`define MS_REG_FREEZE 16'd0
`define MS_REG_CORE_ID 16'd4
`define MS_REG_FINISH 16'd0

// Loader sequence: freeze, core id, unfreeze
`define MS_CFG_STEPS 3
`define MS_CORE_ID_VALUE 32'h0000_0005

`endif

//--- mem_sys_pkg.sv
//#################################################
// Address word types; both views are one address wide
//#################################################
`include "mem_sys_params.svh"

package mem_sys_pkg;

   // DRAM view, byte offset into the array
   typedef struct packed
   {
      logic                        is_dram;
      logic [`MS_ADDR_WIDTH-2:0]   offset;
   } ms_dram_addr_s;

   // I/O view, device and register pair
   typedef struct packed
   {
      logic                        is_dram;
      logic [`MS_ADDR_WIDTH-2-`MS_DEV_WIDTH-`MS_REG_WIDTH:0] pad;
      logic [`MS_DEV_WIDTH-1:0]    dev;
      logic [`MS_REG_WIDTH-1:0]    reg_off;
   } ms_io_addr_s;

   // is_dram sits in the top bit of both views
   typedef union packed
   {
      ms_dram_addr_s               dram;
      ms_io_addr_s                 io;
   } ms_addr_u;

endpackage

//--- mem_sys_top.sv
//#################################################
// Loader, bridge FIFO and target on Wishbone classic
//#################################################
`timescale 1ns/1ns
`include "mem_sys_params.svh"

module mem_sys_top
   import mem_sys_pkg::*;
(
   input  logic                       clk_i,
   input  logic                       rst_n_i,

   input  logic                       ext_cyc_i,
   input  logic                       ext_stb_i,
   input  logic                       ext_we_i,
   input  ms_addr_u                   ext_adr_i,
   input  logic [`MS_DATA_WIDTH-1:0]  ext_dat_i,
   input  logic [`MS_SEL_WIDTH-1:0]   ext_sel_i,
   output logic [`MS_DATA_WIDTH-1:0]  ext_dat_o,
   output logic                       ext_ack_o,
   output logic                       ext_err_o,

   output logic                       cfg_done_o,
   output logic                       freeze_o,
   output logic                       finish_o,
   output logic [`MS_DATA_WIDTH-1:0]  finish_code_o
);

   // Source to bridge
   logic                       src_cyc;
   logic                       src_stb;
   logic                       src_we;
   ms_addr_u                   src_adr;
   logic [`MS_DATA_WIDTH-1:0]  src_dat_w;
   logic [`MS_SEL_WIDTH-1:0]   src_sel;
   logic [`MS_DATA_WIDTH-1:0]  src_dat_r;
   logic                       src_ack;
   logic                       src_err;

   // Bridge to target
   logic                       tgt_cyc;
   logic                       tgt_stb;
   logic                       tgt_we;
   ms_addr_u                   tgt_adr;
   logic [`MS_DATA_WIDTH-1:0]  tgt_dat_w;
   logic [`MS_SEL_WIDTH-1:0]   tgt_sel;
   logic [`MS_DATA_WIDTH-1:0]  tgt_dat_r;
   logic                       tgt_ack;
   logic                       tgt_err;

   cfg_cmd_source u_source
   (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .ext_cyc_i  (ext_cyc_i),
      .ext_stb_i  (ext_stb_i),
      .ext_we_i   (ext_we_i),
      .ext_adr_i  (ext_adr_i),
      .ext_dat_i  (ext_dat_i),
      .ext_sel_i  (ext_sel_i),
      .ext_dat_o  (ext_dat_o),
      .ext_ack_o  (ext_ack_o),
      .ext_err_o  (ext_err_o),
      .src_cyc_o  (src_cyc),
      .src_stb_o  (src_stb),
      .src_we_o   (src_we),
      .src_adr_o  (src_adr),
      .src_dat_o  (src_dat_w),
      .src_sel_o  (src_sel),
      .src_dat_i  (src_dat_r),
      .src_ack_i  (src_ack),
      .src_err_i  (src_err),
      .cfg_done_o (cfg_done_o)
   );

   cmd_bridge_fifo u_bridge
   (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .s_cyc_i (src_cyc),
      .s_stb_i (src_stb),
      .s_we_i  (src_we),
      .s_adr_i (src_adr),
      .s_dat_i (src_dat_w),
      .s_sel_i (src_sel),
      .s_dat_o (src_dat_r),
      .s_ack_o (src_ack),
      .s_err_o (src_err),
      .m_cyc_o (tgt_cyc),
      .m_stb_o (tgt_stb),
      .m_we_o  (tgt_we),
      .m_adr_o (tgt_adr),
      .m_dat_o (tgt_dat_w),
      .m_sel_o (tgt_sel),
      .m_dat_i (tgt_dat_r),
      .m_ack_i (tgt_ack),
      .m_err_i (tgt_err)
   );

   mem_io_target u_target
   (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .cyc_i         (tgt_cyc),
      .stb_i         (tgt_stb),
      .we_i          (tgt_we),
      .adr_i         (tgt_adr),
      .dat_i         (tgt_dat_w),
      .sel_i         (tgt_sel),
      .dat_o         (tgt_dat_r),
      .ack_o         (tgt_ack),
      .err_o         (tgt_err),
      .freeze_o      (freeze_o),
      .finish_o      (finish_o),
      .finish_code_o (finish_code_o)
   );

endmodule

//--- tb_mem_sys.sv
//##################################################
// Directed tests through the ext Wishbone port only
// Loader must finish before any ext transfer completes
//##################################################
`timescale 1ns/1ns
`include "mem_sys_params.svh"

module tb_mem_sys
   import mem_sys_pkg::*;
;

   // About 48 transfers of at most 40 cycles, plus reset and loader time
   localparam int XFER_COUNT      = 48;
   localparam int MAX_XFER_CYCLES = 40;
   localparam int TIMEOUT_CYCLES  = XFER_COUNT * MAX_XFER_CYCLES + 80;

   logic                       clk;
   logic                       rst_n;
   logic                       ext_cyc;
   logic                       ext_stb;
   logic                       ext_we;
   ms_addr_u                   ext_adr;
   logic [`MS_DATA_WIDTH-1:0]  ext_dat_w;
   logic [`MS_SEL_WIDTH-1:0]   ext_sel;
   logic [`MS_DATA_WIDTH-1:0]  ext_dat_r;
   logic                       ext_ack;
   logic                       ext_err;
   logic                       cfg_done;
   logic                       freeze;
   logic                       finish;
   logic [`MS_DATA_WIDTH-1:0]  finish_code;

   logic [15:0]                lfsr;
   logic [`MS_DATA_WIDTH-1:0]  model_mem [`MS_MEM_WORDS];
   int                         err_count;
   int                         check_count;
   int                         test_count;

   mem_sys_top dut
   (
      .clk_i         (clk),
      .rst_n_i       (rst_n),
      .ext_cyc_i     (ext_cyc),
      .ext_stb_i     (ext_stb),
      .ext_we_i      (ext_we),
      .ext_adr_i     (ext_adr),
      .ext_dat_i     (ext_dat_w),
      .ext_sel_i     (ext_sel),
      .ext_dat_o     (ext_dat_r),
      .ext_ack_o     (ext_ack),
      .ext_err_o     (ext_err),
      .cfg_done_o    (cfg_done),
      .freeze_o      (freeze),
      .finish_o      (finish),
      .finish_code_o (finish_code)
   );

   initial
   begin
      clk = 1'b0;
      forever
         #5 clk = ~clk;
   end

   initial
   begin
      repeat (TIMEOUT_CYCLES) @(posedge clk);
      $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("RESULT: FAIL");
      $finish;
   end

   // Fibonacci taps 16, 14, 13, 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = lfsr_next(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   function automatic ms_addr_u dram_addr(input int unsigned idx);
      ms_addr_u a;
      a              = '0;
      a.dram.is_dram = 1'b1;
      a.dram.offset  = (`MS_ADDR_WIDTH-1)'(idx) << 2;
      return a;
   endfunction

   function automatic ms_addr_u io_addr(input logic [7:0] dev, input logic [15:0] reg_off);
      ms_addr_u a;
      a            = '0;
      a.io.dev     = dev;
      a.io.reg_off = reg_off;
      return a;
   endfunction

   task automatic compare_data(input string name, input logic [`MS_DATA_WIDTH-1:0] got,
                               input logic [`MS_DATA_WIDTH-1:0] exp);
      check_count++;
      if (got !== exp)
      begin
         $display("FAILED %s: got 0x%h expected 0x%h", name, got, exp);
         err_count++;
      end
   endtask

   task automatic compare_addr(input string name, input ms_addr_u got, input ms_addr_u exp);
      check_count++;
      if (got !== exp)
      begin
         $display("FAILED %s: got 0x%h expected 0x%h", name, got, exp);
         err_count++;
      end
   endtask

   task automatic compare_flag(input string name, input logic got, input logic exp);
      check_count++;
      if (got !== exp)
      begin
         $display("FAILED %s: got 0x%h expected 0x%h", name, got, exp);
         err_count++;
      end
   endtask

   task automatic drive_request(input logic we, input ms_addr_u adr,
                                input logic [`MS_DATA_WIDTH-1:0] wdat,
                                input logic [`MS_SEL_WIDTH-1:0] sel);
      @(posedge clk);
      ext_cyc   <= 1'b1;
      ext_stb   <= 1'b1;
      ext_we    <= we;
      ext_adr   <= adr;
      ext_dat_w <= wdat;
      ext_sel   <= sel;
   endtask

   task automatic release_bus();
      @(posedge clk);
      ext_cyc <= 1'b0;
      ext_stb <= 1'b0;
      ext_we  <= 1'b0;
   endtask

   task automatic wb_access(input logic we, input ms_addr_u adr,
                            input logic [`MS_DATA_WIDTH-1:0] wdat,
                            input logic [`MS_SEL_WIDTH-1:0] sel,
                            output logic [`MS_DATA_WIDTH-1:0] rdat,
                            output logic acked, output logic erred);
      drive_request(we, adr, wdat, sel);
      do
         @(negedge clk);
      while (!ext_ack && !ext_err);
      rdat  = ext_dat_r;
      acked = ext_ack;
      erred = ext_err;
      release_bus();
   endtask

   task automatic wb_write(input ms_addr_u adr, input logic [`MS_DATA_WIDTH-1:0] wdat,
                           input logic [`MS_SEL_WIDTH-1:0] sel,
                           output logic acked, output logic erred);
      logic [`MS_DATA_WIDTH-1:0] unused_rdat;
      wb_access(1'b1, adr, wdat, sel, unused_rdat, acked, erred);
   endtask

   task automatic wb_read(input ms_addr_u adr, output logic [`MS_DATA_WIDTH-1:0] rdat,
                          output logic acked, output logic erred);
      wb_access(1'b0, adr, '0, '1, rdat, acked, erred);
   endtask

   task automatic report_test(input string name, input int errs_before);
      test_count++;
      $display("Test %s finished with %0d errors", name, err_count - errs_before);
   endtask

   task automatic test_config_load();
      ms_addr_u                   adr;
      logic [`MS_DATA_WIDTH-1:0]  rdat;
      logic                       acked;
      logic                       erred;
      logic                       done_seen;
      int                         errs_before;
      errs_before = err_count;
      done_seen   = 1'b0;
      adr         = io_addr(`MS_DEV_CFG, `MS_REG_CORE_ID);
      compare_addr("core_id address", adr, ms_addr_u'(32'h0002_0004));
      @(negedge clk);
      compare_flag("freeze_o", freeze, 1'b1);
      compare_flag("cfg_done_o", cfg_done, 1'b0);
      compare_flag("finish_o", finish, 1'b0);
      compare_data("finish_code_o", finish_code, '0);
      // Started while the loader still owns the link
      drive_request(1'b0, adr, '0, '1);
      do
      begin
         @(negedge clk);
         if (cfg_done && !done_seen)
         begin
            done_seen = 1'b1;
            compare_flag("freeze_o", freeze, 1'b0);
         end
         if ((ext_ack || ext_err) && !cfg_done)
         begin
            $display("Ext read completed before the config loader was done");
            err_count++;
         end
      end
      while (!ext_ack && !ext_err);
      rdat  = ext_dat_r;
      acked = ext_ack;
      release_bus();
      compare_flag("ext_ack_o", acked, 1'b1);
      compare_data("core_id", rdat, `MS_CORE_ID_VALUE);
      wb_read(io_addr(`MS_DEV_CFG, `MS_REG_FREEZE), rdat, acked, erred);
      compare_flag("ext_ack_o", acked, 1'b1);
      compare_data("freeze", rdat, '0);
      report_test("config_load", errs_before);
   endtask

   task automatic test_dram_round_trip();
      int unsigned                idx_list [6];
      logic [`MS_DATA_WIDTH-1:0]  wdat;
      logic [`MS_DATA_WIDTH-1:0]  rdat;
      logic                       acked;
      logic                       erred;
      int                         errs_before;
      errs_before = err_count;
      for (int i = 0; i < 6; i++)
      begin
         idx_list[i] = rand_bits(10);
         wdat        = rand_bits(32);
         wb_write(dram_addr(idx_list[i]), wdat, '1, acked, erred);
         compare_flag("ext_ack_o", acked, 1'b1);
         model_mem[idx_list[i]] = wdat;
      end
      for (int i = 0; i < 6; i++)
      begin
         wb_read(dram_addr(idx_list[i]), rdat, acked, erred);
         compare_flag("ext_ack_o", acked, 1'b1);
         compare_data("dram word", rdat, model_mem[idx_list[i]]);
      end
      report_test("dram_round_trip", errs_before);
   endtask

   task automatic test_byte_select();
      logic [`MS_DATA_WIDTH-1:0]  rdat;
      logic                       acked;
      logic                       erred;
      int                         errs_before;
      errs_before = err_count;
      wb_write(dram_addr(20), 32'h1122_3344, 4'b1111, acked, erred);
      wb_write(dram_addr(20), 32'hAABB_CCDD, 4'b0101, acked, erred);
      wb_read(dram_addr(20), rdat, acked, erred);
      // Bytes 0 and 2 come from the second write
      compare_data("byte merged word", rdat, 32'h11BB_33DD);
      report_test("byte_select", errs_before);
   endtask

   task automatic test_write_ordering();
      logic [`MS_DATA_WIDTH-1:0]  wdat;
      logic [`MS_DATA_WIDTH-1:0]  rdat;
      logic                       acked;
      logic                       erred;
      int                         errs_before;
      errs_before = err_count;
      for (int i = 0; i < 8; i++)
      begin
         wdat = rand_bits(32);
         wb_write(dram_addr(33), wdat, '1, acked, erred);
         compare_flag("ext_ack_o", acked, 1'b1);
      end
      wb_read(dram_addr(33), rdat, acked, erred);
      compare_data("last written word", rdat, wdat);
      report_test("write_ordering", errs_before);
   endtask

   task automatic test_host_finish();
      logic [`MS_DATA_WIDTH-1:0]  code;
      logic [`MS_DATA_WIDTH-1:0]  rdat;
      logic                       acked;
      logic                       erred;
      int                         errs_before;
      errs_before = err_count;
      code        = rand_bits(32);
      wb_write(io_addr(`MS_DEV_HOST, `MS_REG_FINISH), code, '1, acked, erred);
      // Read is queued behind the posted write
      wb_read(io_addr(`MS_DEV_HOST, `MS_REG_FINISH), rdat, acked, erred);
      compare_data("finish code readback", rdat, code);
      compare_flag("finish_o", finish, 1'b1);
      compare_data("finish_code_o", finish_code, code);
      report_test("host_finish", errs_before);
   endtask

   task automatic test_errors();
      ms_addr_u                   bad_adr [3];
      logic [`MS_DATA_WIDTH-1:0]  rdat;
      logic                       acked;
      logic                       erred;
      int                         errs_before;
      errs_before = err_count;
      bad_adr[0]  = dram_addr(`MS_MEM_WORDS);
      bad_adr[1]  = io_addr(8'h07, 16'h0000);
      bad_adr[2]  = io_addr(`MS_DEV_CFG, 16'h0008);
      compare_addr("past-end address", bad_adr[0], ms_addr_u'(32'h8000_1000));
      for (int i = 0; i < 3; i++)
      begin
         wb_read(bad_adr[i], rdat, acked, erred);
         compare_flag("ext_err_o", erred, 1'b1);
         compare_flag("ext_ack_o", acked, 1'b0);
      end
      wb_write(dram_addr(7), 32'hC0DE_0007, '1, acked, erred);
      // Would alias word 7 if the index were truncated
      wb_write(dram_addr(`MS_MEM_WORDS + 7), 32'hDEAD_BEEF, '1, acked, erred);
      compare_flag("ext_ack_o", acked, 1'b1);
      wb_read(dram_addr(7), rdat, acked, erred);
      compare_data("dram word after bad write", rdat, 32'hC0DE_0007);
      report_test("errors", errs_before);
   endtask

   initial
   begin
      rst_n       = 1'b0;
      ext_cyc     = 1'b0;
      ext_stb     = 1'b0;
      ext_we      = 1'b0;
      ext_adr     = '0;
      ext_dat_w   = '0;
      ext_sel     = '0;
      lfsr        = 16'd43382;
      err_count   = 0;
      check_count = 0;
      test_count  = 0;
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;
      test_config_load();
      test_dram_round_trip();
      test_byte_select();
      test_write_ordering();
      test_host_finish();
      test_errors();
      $display("Tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
      if (err_count == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule
